// ==== cluster/cluster_parity.sv ====
`timescale 1ns/100ps
`include "pu_cfg.svh"

module cluster_parity import pu_pkg::*; #(
    parameter int POS_I = 0,
    parameter int POS_J = 0,
    parameter int POS_K = 0
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  stage_e                                      stage,
    input  logic                                        first_sync,
    input  logic                                        init_is_error_syndrome,
    input  direct_msg_t [`PU_DIRECT_CHANNEL_COUNT-1:0]  direct_in_data,
    input  logic [`PU_DIRECT_CHANNEL_COUNT-1:0]         direct_in_valid,
    input  logic [`PU_NEIGHBOR_COUNT-1:0]               neighbor_is_odd_cluster,
    input  pu_address_u                                 updated_root,
    input  pu_address_u                                 new_root,
    input  logic                                        root_changing,
    input  logic                                        boundary_reached,
    output logic [`PU_DIRECT_CHANNEL_COUNT-1:0]         direct_in_taken,
    output logic                                        is_error_syndrome,
    output logic                                        is_odd_cardinality,
    output logic                                        is_touching_boundary,
    output logic                                        is_odd_cluster,
    output logic                                        broadcast_pending,
    output logic                                        msg_generate,
    output direct_msg_t                                 msg_data
);

    pu_address_u                         self_addr;
    logic                                is_spread;
    logic [`PU_DIRECT_CHANNEL_COUNT-1:0] in_odd;
    logic [`PU_DIRECT_CHANNEL_COUNT-1:0] in_touch;
    logic                                updated_touching;
    logic                                updated_odd_card;
    logic                                myself_odd;
    logic                                any_neighbor_odd;

    assign self_addr = pu_make_address(POS_I, POS_J, POS_K);
    assign is_spread = (stage == stage_spread_cluster);

    // take only messages addressed here while the rest wait on their channel
    always_comb begin
        for (int n = 0; n < `PU_DIRECT_CHANNEL_COUNT; n++) begin
            direct_in_taken[n] = is_spread && direct_in_valid[n]
                                 && (direct_in_data[n].receiver.flat == self_addr.flat);
            in_odd[n]   = direct_in_data[n].is_odd_cardinality;
            in_touch[n] = direct_in_data[n].is_touching_boundary;
        end
    end

    assign updated_odd_card = is_odd_cardinality ^ (^(direct_in_taken & in_odd));
    assign updated_touching = is_touching_boundary | boundary_reached
                              | (|(direct_in_taken & in_touch));

    // tell the new root about our syndrome or a fresh boundary contact
    assign msg_generate = is_spread && (new_root.flat != self_addr.flat)
                          && ((root_changing && is_error_syndrome)
                              || (updated_touching != is_touching_boundary));
    assign msg_data.receiver             = new_root;
    assign msg_data.is_odd_cardinality   = root_changing && is_error_syndrome;
    assign msg_data.is_touching_boundary = updated_touching;

    // only a root that is odd and off the boundary seeds the broadcast
    assign myself_odd = (updated_root.flat == self_addr.flat) && !is_touching_boundary
                        && is_odd_cardinality;
    assign any_neighbor_odd = |neighbor_is_odd_cluster;
    assign broadcast_pending = (stage == stage_sync_is_odd_cluster)
                               && (first_sync ? myself_odd
                                              : (any_neighbor_odd && !is_odd_cluster));

    always_ff @(posedge clk) begin
        if (reset) begin
            is_error_syndrome    <= 1'b0;
            is_odd_cardinality   <= 1'b0;
            is_touching_boundary <= 1'b0;
            is_odd_cluster       <= 1'b0;
        end else begin
            case (stage)
                stage_measurement_loading: begin
                    is_error_syndrome    <= init_is_error_syndrome;
                    is_odd_cardinality   <= init_is_error_syndrome;
                    is_odd_cluster       <= init_is_error_syndrome;
                    is_touching_boundary <= 1'b0;
                end
                stage_spread_cluster: begin
                    is_odd_cardinality   <= updated_odd_card;
                    is_touching_boundary <= updated_touching;
                end
                stage_sync_is_odd_cluster: begin
                    if (first_sync)
                        is_odd_cluster <= myself_odd;
                    else
                        is_odd_cluster <= is_odd_cluster | any_neighbor_odd;   // flood outward
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== cluster/root_election.sv ====
`timescale 1ns/100ps
`include "pu_cfg.svh"

module root_election import pu_pkg::*; #(
    parameter int POS_I = 0,
    parameter int POS_J = 0,
    parameter int POS_K = 0
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  stage_e                                     stage,
    input  logic                                       first_sync,
    input  logic [`PU_NEIGHBOR_COUNT-1:0]              neighbor_is_fully_grown,
    input  pu_address_u [`PU_NEIGHBOR_COUNT-1:0]       neighbor_roots,
    output pu_address_u                                updated_root,
    output pu_address_u                                old_root,
    output pu_address_u                                new_root,
    output logic                                       root_changing
);

    pu_address_u self_addr;

    assign self_addr = pu_make_address(POS_I, POS_J, POS_K);

    // smallest root among own root and the fully grown neighbors
    always_comb begin
        new_root = updated_root;
        for (int n = 0; n < `PU_NEIGHBOR_COUNT; n++) begin
            if (neighbor_is_fully_grown[n] && (neighbor_roots[n].flat < new_root.flat))
                new_root = neighbor_roots[n];
        end
    end

    assign root_changing = (stage == stage_spread_cluster)
                           && (new_root.flat != updated_root.flat);

    always_ff @(posedge clk) begin
        if (reset) begin
            updated_root <= self_addr;
            old_root     <= self_addr;
        end else begin
            case (stage)
                stage_measurement_loading: begin
                    updated_root <= self_addr;   // every unit starts as its own root
                    old_root     <= self_addr;
                end
                stage_spread_cluster: begin
                    updated_root <= new_root;
                end
                stage_sync_is_odd_cluster: begin
                    if (first_sync)
                        old_root <= updated_root;   // published to neighbors from here on
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== common/pu_cfg.svh ====
`ifndef PU_CFG_SVH
`define PU_CFG_SVH

// node address layout with k in the top bits
`define PU_ADDRESS_WIDTH 18
`define PU_COORD_WIDTH 6
`define PU_K_WIDTH (`PU_ADDRESS_WIDTH - 2 * `PU_COORD_WIDTH)

// link counts of one processing unit
`define PU_NEIGHBOR_COUNT 6
`define PU_DIRECT_CHANNEL_COUNT 3

// code distance along j
`define PU_CODE_DISTANCE_Z 12

// boundary costs that fit in two bits
`define PU_BOUNDARY_WIDTH 2
`define PU_BOUNDARY_COST_Z 2
`define PU_BOUNDARY_COST_UD 2

`endif

// ==== common/pu_pkg.sv ====
`include "pu_cfg.svh"

package pu_pkg;

    // stage code driven by the decoder controller
    typedef enum logic [2:0] {
        stage_idle                = 3'd0,
        stage_spread_cluster      = 3'd1,
        stage_grow_boundary       = 3'd2,
        stage_sync_is_odd_cluster = 3'd3,
        stage_measurement_loading = 3'd4
    } stage_e;

    // flat view for root compare, coordinate view for boundary checks
    typedef union packed {
        logic [`PU_ADDRESS_WIDTH-1:0] flat;
        struct packed {
            logic [`PU_K_WIDTH-1:0]     k;
            logic [`PU_COORD_WIDTH-1:0] i;
            logic [`PU_COORD_WIDTH-1:0] j;
        } coord;
    } pu_address_u;

    typedef struct packed {
        pu_address_u receiver;
        logic        is_odd_cardinality;
        logic        is_touching_boundary;
    } direct_msg_t;

    // address of the unit sitting at (i, j, k)
    function automatic pu_address_u pu_make_address(input int i, input int j, input int k);
        pu_address_u a;
        a.coord.k = k[`PU_K_WIDTH-1:0];
        a.coord.i = i[`PU_COORD_WIDTH-1:0];
        a.coord.j = j[`PU_COORD_WIDTH-1:0];
        return a;
    endfunction

endpackage

// ==== dv/pu_testdata.txt ====
// stage syndrome grown_mask odd_mask neighbor_roots in_valid in_data out_full hold
// exp_updated_root exp_old_root exp_flags exp_taken_seen exp_out_data, flags bit0..7 =
// processing odd_cluster touching odd_card syndrome out_valid increase_seen check_out_data
0 0 00 00 0                           0 000000000000000 0 3 00080 00080 00 0 00000
4 1 00 00 0                           0 000000000000000 0 3 00080 00080 1a 0 00000
1 1 05 00 fffffffffffffc0100000400050 0 000000000000000 1 4 00050 00080 bb 0 00142
1 1 05 00 fffffffffffffc0100000400050 0 000000000000000 0 3 00050 00080 1a 0 00000
1 1 05 00 fffffffffffffc0100000400050 3 000000020600202 0 3 00050 00080 13 1 00000
2 1 00 00 0                           0 000000000000000 0 3 00050 00080 52 0 00000
0 1 00 00 0                           0 000000000000000 0 3 00050 00080 12 0 00000
2 1 00 00 0                           0 000000000000000 0 3 00050 00080 52 0 00000
1 1 05 00 fffffffffffffc0100000400050 0 000000000000000 0 3 00050 00080 96 0 00141
3 1 00 00 0                           0 000000000000000 0 3 00050 00050 14 0 00000
3 1 00 02 0                           0 000000000000000 0 3 00050 00050 16 0 00000
2 1 00 00 0                           0 000000000000000 0 3 00050 00050 56 0 00000
4 0 00 00 0                           0 000000000000000 0 3 00080 00080 00 0 00000
2 0 00 00 0                           0 000000000000000 0 3 00080 00080 00 0 00000
0 0 00 00 0                           0 000000000000000 0 3 00080 00080 00 0 00000
4 1 00 00 0                           0 000000000000000 0 3 00080 00080 1a 0 00000
3 1 00 00 0                           0 000000000000000 0 3 00080 00080 1a 0 00000
2 1 00 00 0                           0 000000000000000 0 3 00080 00080 5a 0 00000

// ==== dv/tb_processing_unit.sv ====
`timescale 1ns/100ps
`include "pu_cfg.svh"

module tb_processing_unit import pu_pkg::*; ();

    localparam int POS_I = 2;   // j = 0 and k = 0, so both z and up-down boundaries
    localparam int POS_J = 0;
    localparam int POS_K = 0;
    localparam int RESET_CYCLES = 5;
    localparam int FIELDS = 14;   // hex words per vector line
    localparam int MAX_LINES = 64;
    localparam int ROOTS_W = `PU_NEIGHBOR_COUNT * `PU_ADDRESS_WIDTH;
    localparam int IN_W = `PU_DIRECT_CHANNEL_COUNT * $bits(direct_msg_t);

    // column order of a vector line
    localparam int F_STAGE = 0;
    localparam int F_SYNDROME = 1;
    localparam int F_GROWN = 2;
    localparam int F_ODD = 3;
    localparam int F_ROOTS = 4;
    localparam int F_IN_VALID = 5;
    localparam int F_IN_DATA = 6;
    localparam int F_OUT_FULL = 7;
    localparam int F_HOLD = 8;
    localparam int F_EXP_UROOT = 9;
    localparam int F_EXP_OROOT = 10;
    localparam int F_EXP_FLAGS = 11;
    localparam int F_EXP_TAKEN = 12;
    localparam int F_EXP_OUT_DATA = 13;

    logic                                       clk;
    logic                                       reset;
    logic                                       init_is_error_syndrome;
    stage_e                                     stage_in;
    logic [`PU_NEIGHBOR_COUNT-1:0]              neighbor_is_fully_grown;
    logic [`PU_NEIGHBOR_COUNT-1:0]              neighbor_is_odd_cluster;
    pu_address_u [`PU_NEIGHBOR_COUNT-1:0]       neighbor_roots;
    direct_msg_t [`PU_DIRECT_CHANNEL_COUNT-1:0] direct_in_data;
    logic [`PU_DIRECT_CHANNEL_COUNT-1:0]        direct_in_valid;
    logic                                       direct_out_full;
    logic                                       neighbor_increase;
    logic [`PU_DIRECT_CHANNEL_COUNT-1:0]        direct_in_taken;
    direct_msg_t                                direct_out_data;
    logic                                       direct_out_valid;
    pu_address_u                                old_root;
    pu_address_u                                updated_root;
    logic                                       is_error_syndrome;
    logic                                       is_odd_cluster;
    logic                                       is_touching_boundary;
    logic                                       is_odd_cardinality;
    logic                                       is_processing;

    logic [127:0] vec_mem [0:FIELDS*MAX_LINES-1];
    int           num_lines;
    int           total_hold;   // sum of hold counts that sizes the watchdog
    int           check_count;
    int           error_count;
    bit           vectors_loaded;

    processing_unit #(.POS_I(POS_I), .POS_J(POS_J), .POS_K(POS_K)) i_processing_unit (
        .clk, .reset, .init_is_error_syndrome, .stage_in,
        .neighbor_is_fully_grown, .neighbor_is_odd_cluster, .neighbor_roots,
        .direct_in_data, .direct_in_valid, .direct_out_full,
        .neighbor_increase, .direct_in_taken, .direct_out_data, .direct_out_valid,
        .old_root, .updated_root, .is_error_syndrome, .is_odd_cluster,
        .is_touching_boundary, .is_odd_cardinality, .is_processing
    );

    always #5 clk = ~clk;   // 10 ns period

    task automatic compare_value(input string what, input logic [127:0] actual,
                                 input logic [127:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at time %0d ns: %s is %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // one line of stimulus onto the DUT inputs
    task automatic apply_vector(input int base);
        stage_in                = stage_e'(vec_mem[base + F_STAGE][2:0]);
        init_is_error_syndrome  = vec_mem[base + F_SYNDROME][0];
        neighbor_is_fully_grown = vec_mem[base + F_GROWN][`PU_NEIGHBOR_COUNT-1:0];
        neighbor_is_odd_cluster = vec_mem[base + F_ODD][`PU_NEIGHBOR_COUNT-1:0];
        neighbor_roots          = vec_mem[base + F_ROOTS][ROOTS_W-1:0];
        direct_in_valid         = vec_mem[base + F_IN_VALID][`PU_DIRECT_CHANNEL_COUNT-1:0];
        direct_in_data          = vec_mem[base + F_IN_DATA][IN_W-1:0];
        direct_out_full         = vec_mem[base + F_OUT_FULL][0];
    endtask

    task automatic check_vector(input int line, input int base,
                                input logic [`PU_DIRECT_CHANNEL_COUNT-1:0] taken_seen,
                                input logic increase_seen);
        logic [7:0] flags;
        flags = vec_mem[base + F_EXP_FLAGS][7:0];   // packed expected status bits
        compare_value($sformatf("line %0d updated_root", line),
                      128'(updated_root.flat), vec_mem[base + F_EXP_UROOT]);
        compare_value($sformatf("line %0d old_root", line),
                      128'(old_root.flat), vec_mem[base + F_EXP_OROOT]);
        compare_value($sformatf("line %0d is_processing", line),
                      128'(is_processing), 128'(flags[0]));
        compare_value($sformatf("line %0d is_odd_cluster", line),
                      128'(is_odd_cluster), 128'(flags[1]));
        compare_value($sformatf("line %0d is_touching_boundary", line),
                      128'(is_touching_boundary), 128'(flags[2]));
        compare_value($sformatf("line %0d is_odd_cardinality", line),
                      128'(is_odd_cardinality), 128'(flags[3]));
        compare_value($sformatf("line %0d is_error_syndrome", line),
                      128'(is_error_syndrome), 128'(flags[4]));
        compare_value($sformatf("line %0d direct_out_valid", line),
                      128'(direct_out_valid), 128'(flags[5]));
        compare_value($sformatf("line %0d neighbor_increase seen", line),
                      128'(increase_seen), 128'(flags[6]));
        compare_value($sformatf("line %0d direct_in_taken seen", line),
                      128'(taken_seen), vec_mem[base + F_EXP_TAKEN]);
        if (flags[7])   // message word only meaningful once one was built
            compare_value($sformatf("line %0d direct_out_data", line),
                          128'(direct_out_data), vec_mem[base + F_EXP_OUT_DATA]);
    endtask

    initial begin : stimulus
        int                                  base;
        int                                  hold;
        logic [`PU_DIRECT_CHANNEL_COUNT-1:0] consumed;
        logic [`PU_DIRECT_CHANNEL_COUNT-1:0] taken_seen;
        logic                                increase_seen;

        clk                     = 1'b0;
        reset                   = 1'b1;
        init_is_error_syndrome  = 1'b0;
        stage_in                = stage_idle;
        neighbor_is_fully_grown = '0;
        neighbor_is_odd_cluster = '0;
        neighbor_roots          = '0;
        direct_in_data          = '0;
        direct_in_valid         = '0;
        direct_out_full         = 1'b0;
        check_count             = 0;
        error_count             = 0;

        for (int a = 0; a < FIELDS * MAX_LINES; a++)
            vec_mem[a] = '1;   // an all-ones stage word ends the table
        $readmemh("dv/pu_testdata.txt", vec_mem);
        num_lines  = 0;
        total_hold = 0;
        while (num_lines < MAX_LINES && vec_mem[num_lines * FIELDS][127:3] == '0) begin
            hold = int'(vec_mem[num_lines * FIELDS + F_HOLD][15:0]);
            if (hold < 3) begin
                error_count++;
                $display("vector line %0d holds for fewer than 3 cycles", num_lines + 1);
            end
            total_hold += hold;
            num_lines++;
        end
        if (num_lines == 0) begin
            error_count++;
            $display("no vectors were read from dv/pu_testdata.txt");
        end
        vectors_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int line = 0; line < num_lines; line++) begin
            base = line * FIELDS;
            hold = int'(vec_mem[base + F_HOLD][15:0]);
            apply_vector(base);
            taken_seen    = '0;
            increase_seen = 1'b0;
            for (int c = 0; c < hold; c++) begin
                #1;   // mid low phase where nothing moves until the next rising edge
                consumed      = direct_in_taken;
                taken_seen    = taken_seen | direct_in_taken;
                increase_seen = increase_seen | neighbor_increase;
                @(negedge clk);
                if (c < hold - 1)
                    direct_in_valid = direct_in_valid & ~consumed;   // channel pops taken words
            end
            check_vector(line + 1, base, taken_seen, increase_seen);
        end

        $display("vectors: %0d, checks: %0d, errors: %0d", num_lines, check_count, error_count);
        if (error_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial begin : watchdog
        wait (vectors_loaded);
        repeat (total_hold + 20) @(posedge clk);   // reset fits inside the margin
        error_count++;
        $display("timeout: the vectors did not finish within %0d clock cycles",
                 total_hold + 20);
        $display("vectors: %0d, checks: %0d, errors: %0d", num_lines, check_count, error_count);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+common
common/pu_pkg.sv
src/stage_tracker.sv
src/boundary_growth.sv
cluster/root_election.sv
cluster/cluster_parity.sv
src/direct_message_out.sv
src/processing_unit.sv
dv/tb_processing_unit.sv

// ==== run.sh ====
#!/bin/sh
# builds the processing unit testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --Mdir obj_dir --top-module tb_processing_unit \
    -o tb_processing_unit -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_processing_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    exit 1
fi
exit 0

// ==== src/boundary_growth.sv ====
`timescale 1ns/100ps
`include "pu_cfg.svh"

module boundary_growth import pu_pkg::*; #(
    parameter int POS_I = 0,
    parameter int POS_J = 0,
    parameter int POS_K = 0
) (
    input  logic   clk,
    input  logic   reset,
    input  stage_e stage,
    input  logic   first_grow,
    input  logic   is_odd_cluster,
    output logic   boundary_reached
);

    localparam int BW = `PU_BOUNDARY_WIDTH;

    pu_address_u          self_addr;
    logic [1:0]           has_boundary;   // [0] z, [1] up-down
    logic [1:0][BW-1:0]   cost;
    logic [1:0][BW-1:0]   grown;
    logic [1:0]           at_cost;

    assign self_addr = pu_make_address(POS_I, POS_J, POS_K);

    // z boundary on both j edges, up-down boundary on the first round only
    assign has_boundary[0] = (self_addr.coord.j == 0)
                             || (self_addr.coord.j == `PU_CODE_DISTANCE_Z - 1);
    assign has_boundary[1] = (self_addr.coord.k == 0);

    assign cost[0] = BW'(`PU_BOUNDARY_COST_Z);
    assign cost[1] = BW'(`PU_BOUNDARY_COST_UD);

    always_ff @(posedge clk) begin
        if (reset) begin
            grown <= '0;
        end else if (stage == stage_measurement_loading) begin
            grown <= '0;
        end else if (first_grow && is_odd_cluster) begin
            for (int n = 0; n < 2; n++) begin
                if (has_boundary[n] && (grown[n] < cost[n]))
                    grown[n] <= grown[n] + 1'b1;   // saturates at cost
            end
        end
    end

    always_comb begin
        for (int n = 0; n < 2; n++)
            at_cost[n] = has_boundary[n] && (grown[n] == cost[n]);
    end

    assign boundary_reached = |at_cost;

endmodule

// ==== src/direct_message_out.sv ====
`timescale 1ns/100ps
`include "pu_cfg.svh"

module direct_message_out import pu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  stage_e      stage,
    input  logic        msg_generate,
    input  direct_msg_t msg_data,
    input  logic        direct_out_full,
    output direct_msg_t direct_out_data,
    output logic        direct_out_valid,
    output logic        out_pending
);

    direct_msg_t stored_msg;
    logic        pending;

    // a newer message replaces one still waiting
    always_ff @(posedge clk) begin
        if (msg_generate)
            stored_msg <= msg_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (stage == stage_measurement_loading) begin
            pending <= 1'b0;
        end else if (msg_generate) begin
            pending <= 1'b1;
        end else if (direct_out_valid && !direct_out_full) begin
            pending <= 1'b0;   // channel accepted it
        end
    end

    assign direct_out_valid = pending && (stage == stage_spread_cluster);
    assign direct_out_data  = stored_msg;
    assign out_pending      = pending;

endmodule

// ==== src/processing_unit.sv ====
`timescale 1ns/100ps
`include "pu_cfg.svh"

module processing_unit import pu_pkg::*; #(
    parameter int POS_I = 0,
    parameter int POS_J = 0,
    parameter int POS_K = 0
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        init_is_error_syndrome,
    input  stage_e                                      stage_in,
    input  logic [`PU_NEIGHBOR_COUNT-1:0]               neighbor_is_fully_grown,
    input  logic [`PU_NEIGHBOR_COUNT-1:0]               neighbor_is_odd_cluster,
    input  pu_address_u [`PU_NEIGHBOR_COUNT-1:0]        neighbor_roots,
    input  direct_msg_t [`PU_DIRECT_CHANNEL_COUNT-1:0]  direct_in_data,
    input  logic [`PU_DIRECT_CHANNEL_COUNT-1:0]         direct_in_valid,
    input  logic                                        direct_out_full,
    output logic                                        neighbor_increase,
    output logic [`PU_DIRECT_CHANNEL_COUNT-1:0]         direct_in_taken,
    output direct_msg_t                                 direct_out_data,
    output logic                                        direct_out_valid,
    output pu_address_u                                 old_root,
    output pu_address_u                                 updated_root,
    output logic                                        is_error_syndrome,
    output logic                                        is_odd_cluster,
    output logic                                        is_touching_boundary,
    output logic                                        is_odd_cardinality,
    output logic                                        is_processing
);

    stage_e      stage;
    logic        first_grow, first_sync;
    logic        root_changing, broadcast_pending, out_pending;
    logic        boundary_reached, msg_generate;
    pu_address_u new_root;
    direct_msg_t msg_data;

    // grow trigger toward the neighbor links once per grow stage
    assign neighbor_increase = first_grow & is_odd_cluster;

    stage_tracker u_stage_tracker (
        .clk, .reset, .stage_in, .root_changing, .broadcast_pending,
        .direct_in_valid, .out_pending,
        .stage, .first_grow, .first_sync, .is_processing
    );

    boundary_growth #(.POS_I(POS_I), .POS_J(POS_J), .POS_K(POS_K)) u_boundary_growth (
        .clk, .reset, .stage, .first_grow, .is_odd_cluster, .boundary_reached
    );

    root_election #(.POS_I(POS_I), .POS_J(POS_J), .POS_K(POS_K)) u_root_election (
        .clk, .reset, .stage, .first_sync, .neighbor_is_fully_grown, .neighbor_roots,
        .updated_root, .old_root, .new_root, .root_changing
    );

    cluster_parity #(.POS_I(POS_I), .POS_J(POS_J), .POS_K(POS_K)) u_cluster_parity (
        .clk, .reset, .stage, .first_sync, .init_is_error_syndrome,
        .direct_in_data, .direct_in_valid, .neighbor_is_odd_cluster,
        .updated_root, .new_root, .root_changing, .boundary_reached,
        .direct_in_taken, .is_error_syndrome, .is_odd_cardinality,
        .is_touching_boundary, .is_odd_cluster, .broadcast_pending,
        .msg_generate, .msg_data
    );

    direct_message_out u_direct_message_out (
        .clk, .reset, .stage, .msg_generate, .msg_data, .direct_out_full,
        .direct_out_data, .direct_out_valid, .out_pending
    );

endmodule

// ==== src/stage_tracker.sv ====
`timescale 1ns/100ps
`include "pu_cfg.svh"

module stage_tracker import pu_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,
    input  stage_e                              stage_in,
    input  logic                                root_changing,
    input  logic                                broadcast_pending,
    input  logic [`PU_DIRECT_CHANNEL_COUNT-1:0] direct_in_valid,
    input  logic                                out_pending,
    output stage_e                              stage,
    output logic                                first_grow,
    output logic                                first_sync,
    output logic                                is_processing
);

    stage_e last_stage;
    logic   activity;
    logic   activity_d;   // activity held one more cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            stage      <= stage_idle;
            last_stage <= stage_idle;
            activity_d <= 1'b0;
        end else begin
            stage      <= stage_in;
            // after loading, whatever stage comes next counts as new
            last_stage <= (stage == stage_measurement_loading) ? stage_idle : stage;
            activity_d <= activity;
        end
    end

    // single cycle strobes on stage entry
    assign first_grow = (stage == stage_grow_boundary) && (last_stage != stage_grow_boundary);
    assign first_sync = (stage == stage_sync_is_odd_cluster)
                        && (last_stage != stage_sync_is_odd_cluster);

    assign activity = root_changing | broadcast_pending;   // neighbors will see a change

    // busy while anything may still move in this unit or on its channels
    assign is_processing = activity | activity_d | (|direct_in_valid) | out_pending;

endmodule
